//--- src/cpu_settings.svh
// CPU core settings
// Widths and sizes shared by the pipeline stages and the package
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath width in bits
`define CPU_XLEN 64

// Architectural registers, zero register included
`define CPU_NUM_REGS 32

// Register that always reads as zero
`define CPU_ZERO_REG 31

// Data memory size in doublewords
`define CPU_DMEM_WORDS 32

`endif

//--- src/cpu_pkg.sv
`include "cpu_settings.svh"

// CPU core package
// Data and register types, the instruction word views,
// forwarding codes, ALU operations and opcodes
package cpu_pkg;

	// One datapath word
	typedef logic [`CPU_XLEN-1:0] word_t;

	// Register number
	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

	// Same 32 bits seen as R, I or D format
	typedef union packed {
		struct packed {
			logic [10:0] opcode;
			reg_idx_t    rm;
			logic [5:0]  shamt;
			reg_idx_t    rn;
			reg_idx_t    rd;
		} r_fmt;
		struct packed {
			logic [9:0]  opcode;
			logic [11:0] imm;
			reg_idx_t    rn;
			reg_idx_t    rd;
		} i_fmt;
		struct packed {
			logic [10:0] opcode;
			logic [8:0]  addr;
			logic [1:0]  op2;
			reg_idx_t    rn;
			reg_idx_t    rt;
		} d_fmt;
	} instr_u;

	// Which operands of the EX instruction may be forwarded
	typedef enum logic [1:0] {
		FWD_NONE  = 2'b00,
		FWD_STORE = 2'b01,
		FWD_IMM   = 2'b10,
		FWD_REG   = 2'b11
	} fwd_en_e;

	// Operand source in EX
	typedef enum logic [1:0] {
		FWD_PASS         = 2'b00,
		FWD_MEM_WB       = 2'b01,
		FWD_EX_MEM       = 2'b10,
		FWD_STORE_EX_MEM = 2'b11
	} fwd_sel_e;

	typedef enum logic [1:0] {
		ALU_ADD = 2'b00,
		ALU_SUB = 2'b01,
		ALU_AND = 2'b10,
		ALU_ORR = 2'b11
	} alu_op_e;

	// R and D format opcodes
	localparam logic [10:0] OP_ADD  = 11'b10001011000;
	localparam logic [10:0] OP_SUB  = 11'b11001011000;
	localparam logic [10:0] OP_AND  = 11'b10001010000;
	localparam logic [10:0] OP_ORR  = 11'b10101010000;
	localparam logic [10:0] OP_LDUR = 11'b11111000010;
	localparam logic [10:0] OP_STUR = 11'b11111000000;
	// I format opcodes, 10 bits wide
	localparam logic [9:0]  OP_ADDI = 10'b1001000100;
	localparam logic [9:0]  OP_SUBI = 10'b1101000100;

endpackage

//--- src/forwarding.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

// Forwarding unit
// Picks the EX operand and store data sources from the targets held
// in the ID/EX, EX/MEM and MEM/WB registers. Purely combinational
module forwarding (
	input  cpu_pkg::fwd_en_e  fwd_en_ex,
	input  logic              reg_write_ex,
	input  logic              reg_write_mem,
	input  logic              reg_write_wb,
	input  cpu_pkg::reg_idx_t target_ex,
	input  cpu_pkg::reg_idx_t target_mem,
	input  cpu_pkg::reg_idx_t target_wb,
	input  cpu_pkg::reg_idx_t rn_ex,
	input  cpu_pkg::reg_idx_t rm_ex,
	output cpu_pkg::fwd_sel_e fwd_a,
	output cpu_pkg::fwd_sel_e fwd_b,
	output logic              store_sel
);
	localparam cpu_pkg::reg_idx_t ZERO_REG = cpu_pkg::reg_idx_t'(`CPU_ZERO_REG);

	logic a_mem;
	logic a_wb;
	logic b_mem;
	logic b_wb;
	logic st_mem;
	logic st_wb;

	// Pipeline register writes src and is not X31
	function automatic logic hit(input logic we, input cpu_pkg::reg_idx_t tgt,
			input cpu_pkg::reg_idx_t src);
		return we && (tgt != ZERO_REG) && (tgt == src);
	endfunction

	// Match tests per source
	assign a_mem = hit(reg_write_mem, target_mem, rn_ex);
	assign a_wb  = hit(reg_write_wb, target_wb, rn_ex);
	assign b_mem = hit(reg_write_mem, target_mem, rm_ex);
	assign b_wb  = hit(reg_write_wb, target_wb, rm_ex);
	// Store data compares against Rt, held as the EX target
	assign st_mem = hit(reg_write_mem, target_mem, target_ex) && !reg_write_ex;
	assign st_wb  = hit(reg_write_wb, target_wb, target_ex);

	assign store_sel = (fwd_en_ex == cpu_pkg::FWD_STORE);

	always_comb begin
		fwd_a = cpu_pkg::FWD_PASS;
		fwd_b = cpu_pkg::FWD_PASS;
		// Rn checked for every forwarding form
		if (fwd_en_ex != cpu_pkg::FWD_NONE) begin
			// Younger EX/MEM result wins
			if (a_mem)
				fwd_a = cpu_pkg::FWD_EX_MEM;
			else if (a_wb)
				fwd_a = cpu_pkg::FWD_MEM_WB;
		end
		case (fwd_en_ex)
			// R-type, Rm is the second operand
			cpu_pkg::FWD_REG: begin
				if (b_mem)
					fwd_b = cpu_pkg::FWD_EX_MEM;
				else if (b_wb)
					fwd_b = cpu_pkg::FWD_MEM_WB;
			end
			// STUR, forwarded value goes to the store data
			cpu_pkg::FWD_STORE: begin
				if (st_mem)
					fwd_b = cpu_pkg::FWD_STORE_EX_MEM;
				else if (st_wb)
					fwd_b = cpu_pkg::FWD_MEM_WB;
			end
			// I-type and bubbles use no second register
			default: fwd_b = cpu_pkg::FWD_PASS;
		endcase
	end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

// Register file
// 31 general registers plus X31 hard wired to zero,
// two read ports with write-through from the writeback port
module reg_file (
	input  logic              clk,
	input  logic              rst_n,
	input  cpu_pkg::reg_idx_t rd_addr_a,
	input  cpu_pkg::reg_idx_t rd_addr_b,
	input  logic              wr_en,
	input  cpu_pkg::reg_idx_t wr_addr,
	input  cpu_pkg::word_t    wr_data,
	output cpu_pkg::word_t    rd_data_a,
	output cpu_pkg::word_t    rd_data_b
);
	localparam cpu_pkg::reg_idx_t ZERO_REG = cpu_pkg::reg_idx_t'(`CPU_ZERO_REG);

	// No storage behind X31
	cpu_pkg::word_t regs [0:`CPU_ZERO_REG-1];
	logic           wr_ok;

	assign wr_ok = wr_en && (wr_addr != ZERO_REG);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_ZERO_REG; i++)
				regs[i] <= '0;
		end else if (wr_ok) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Zero first, then same-cycle bypass, then stored value
	assign rd_data_a = (rd_addr_a == ZERO_REG) ? '0 :
		(wr_ok && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == ZERO_REG) ? '0 :
		(wr_ok && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

// Decode stage
// Decodes the strobed instruction word by format, drives the
// register read addresses and loads the ID/EX pipeline register
module decode_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  cpu_pkg::instr_u   instr,
	input  cpu_pkg::word_t    rd_data_a,
	input  cpu_pkg::word_t    rd_data_b,
	output cpu_pkg::reg_idx_t rd_addr_a,
	output cpu_pkg::reg_idx_t rd_addr_b,
	output logic              valid_ex,
	output logic              reg_write_ex,
	output logic              mem_read_ex,
	output logic              mem_write_ex,
	output cpu_pkg::alu_op_e  alu_op_ex,
	output cpu_pkg::fwd_en_e  fwd_en_ex,
	output cpu_pkg::reg_idx_t target_ex,
	output cpu_pkg::reg_idx_t rn_ex,
	output cpu_pkg::reg_idx_t rm_ex,
	output cpu_pkg::word_t    op_a_ex,
	output cpu_pkg::word_t    op_b_ex,
	output cpu_pkg::word_t    imm_ex
);
	logic              dec_ok;
	logic              dec_reg_write;
	logic              dec_mem_read;
	logic              dec_mem_write;
	cpu_pkg::alu_op_e  dec_alu_op;
	cpu_pkg::fwd_en_e  dec_fwd_en;
	cpu_pkg::reg_idx_t dec_target;
	cpu_pkg::word_t    dec_imm;
	cpu_pkg::word_t    d_offset;
	logic              take;

	// D-format offset is signed
	assign d_offset = {{(`CPU_XLEN-9){instr.d_fmt.addr[8]}}, instr.d_fmt.addr};

	always_comb begin
		dec_ok        = 1'b1;
		dec_reg_write = 1'b0;
		dec_mem_read  = 1'b0;
		dec_mem_write = 1'b0;
		dec_alu_op    = cpu_pkg::ALU_ADD;
		dec_fwd_en    = cpu_pkg::FWD_NONE;
		dec_target    = instr.r_fmt.rd;
		dec_imm       = '0;
		case (instr.r_fmt.opcode)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_ORR: begin
				dec_reg_write = 1'b1;
				dec_fwd_en    = cpu_pkg::FWD_REG;
				if (instr.r_fmt.opcode == cpu_pkg::OP_SUB)
					dec_alu_op = cpu_pkg::ALU_SUB;
				else if (instr.r_fmt.opcode == cpu_pkg::OP_AND)
					dec_alu_op = cpu_pkg::ALU_AND;
				else if (instr.r_fmt.opcode == cpu_pkg::OP_ORR)
					dec_alu_op = cpu_pkg::ALU_ORR;
			end
			// Address is Rn plus offset, ALU adds
			cpu_pkg::OP_LDUR: begin
				dec_reg_write = 1'b1;
				dec_mem_read  = 1'b1;
				dec_fwd_en    = cpu_pkg::FWD_IMM;
				dec_target    = instr.d_fmt.rt;
				dec_imm       = d_offset;
			end
			// Rt is the store data, kept as target for forwarding
			cpu_pkg::OP_STUR: begin
				dec_mem_write = 1'b1;
				dec_fwd_en    = cpu_pkg::FWD_STORE;
				dec_target    = instr.d_fmt.rt;
				dec_imm       = d_offset;
			end
			default: begin
				// I-format has a shorter opcode
				dec_imm = cpu_pkg::word_t'(instr.i_fmt.imm);
				if (instr.i_fmt.opcode == cpu_pkg::OP_ADDI ||
						instr.i_fmt.opcode == cpu_pkg::OP_SUBI) begin
					dec_reg_write = 1'b1;
					dec_fwd_en    = cpu_pkg::FWD_IMM;
					if (instr.i_fmt.opcode == cpu_pkg::OP_SUBI)
						dec_alu_op = cpu_pkg::ALU_SUB;
				end else begin
					// Unknown opcode
					dec_ok = 1'b0;
				end
			end
		endcase
	end

	assign take = instr_valid && dec_ok;

	// Port B reads Rt for a store
	assign rd_addr_a = instr.r_fmt.rn;
	assign rd_addr_b = dec_mem_write ? instr.d_fmt.rt : instr.r_fmt.rm;

	// ID/EX control, bubble when nothing is taken
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_ex     <= 1'b0;
			reg_write_ex <= 1'b0;
			mem_read_ex  <= 1'b0;
			mem_write_ex <= 1'b0;
			fwd_en_ex    <= cpu_pkg::FWD_NONE;
			target_ex    <= '0;
			rn_ex        <= '0;
			rm_ex        <= '0;
		end else begin
			valid_ex     <= take;
			reg_write_ex <= take && dec_reg_write;
			mem_read_ex  <= take && dec_mem_read;
			mem_write_ex <= take && dec_mem_write;
			fwd_en_ex    <= take ? dec_fwd_en : cpu_pkg::FWD_NONE;
			target_ex    <= dec_target;
			rn_ex        <= instr.r_fmt.rn;
			rm_ex        <= instr.r_fmt.rm;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		alu_op_ex <= dec_alu_op;
		op_a_ex   <= rd_data_a;
		op_b_ex   <= rd_data_b;
		imm_ex    <= dec_imm;
	end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ns

// Execute stage
// Forwarding muxes in front of the ALU and the store data,
// then the EX/MEM pipeline register
module execute_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              valid_ex,
	input  logic              reg_write_ex,
	input  logic              mem_read_ex,
	input  logic              mem_write_ex,
	input  cpu_pkg::alu_op_e  alu_op_ex,
	input  cpu_pkg::fwd_en_e  fwd_en_ex,
	input  cpu_pkg::reg_idx_t target_ex,
	input  cpu_pkg::word_t    op_a_ex,
	input  cpu_pkg::word_t    op_b_ex,
	input  cpu_pkg::word_t    imm_ex,
	input  cpu_pkg::fwd_sel_e fwd_a,
	input  cpu_pkg::fwd_sel_e fwd_b,
	input  logic              store_sel,
	input  cpu_pkg::word_t    wb_data,
	output logic              valid_mem,
	output logic              reg_write_mem,
	output logic              mem_read_mem,
	output logic              mem_write_mem,
	output cpu_pkg::reg_idx_t target_mem,
	output cpu_pkg::word_t    alu_result_mem,
	output cpu_pkg::word_t    store_data_mem
);
	cpu_pkg::word_t a_val;
	cpu_pkg::word_t b_val;
	cpu_pkg::word_t alu_b;
	cpu_pkg::word_t alu_out;

	// Both EX/MEM codes take the ALU result one stage ahead
	always_comb begin
		case (fwd_a)
			cpu_pkg::FWD_MEM_WB: a_val = wb_data;
			cpu_pkg::FWD_EX_MEM, cpu_pkg::FWD_STORE_EX_MEM: a_val = alu_result_mem;
			default: a_val = op_a_ex;
		endcase
		case (fwd_b)
			cpu_pkg::FWD_MEM_WB: b_val = wb_data;
			cpu_pkg::FWD_EX_MEM, cpu_pkg::FWD_STORE_EX_MEM: b_val = alu_result_mem;
			default: b_val = op_b_ex;
		endcase
	end

	// Immediate or offset as B for I and D forms
	assign alu_b = (store_sel || fwd_en_ex == cpu_pkg::FWD_IMM) ? imm_ex : b_val;

	always_comb begin
		case (alu_op_ex)
			cpu_pkg::ALU_SUB: alu_out = a_val - alu_b;
			cpu_pkg::ALU_AND: alu_out = a_val & alu_b;
			cpu_pkg::ALU_ORR: alu_out = a_val | alu_b;
			default:          alu_out = a_val + alu_b;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_mem     <= 1'b0;
			reg_write_mem <= 1'b0;
			mem_read_mem  <= 1'b0;
			mem_write_mem <= 1'b0;
			target_mem    <= '0;
		end else begin
			valid_mem     <= valid_ex;
			reg_write_mem <= reg_write_ex;
			mem_read_mem  <= mem_read_ex;
			mem_write_mem <= mem_write_ex;
			target_mem    <= target_ex;
		end
	end

	// Forwarded Rt replaces the read value for stores
	always_ff @(posedge clk) begin
		alu_result_mem <= alu_out;
		store_data_mem <= store_sel ? b_val : op_b_ex;
	end

endmodule

//--- src/memory_stage.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

// Memory stage
// Data memory with combinational read, store port and the
// MEM/WB pipeline register
module memory_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              valid_mem,
	input  logic              reg_write_mem,
	input  logic              mem_read_mem,
	input  logic              mem_write_mem,
	input  cpu_pkg::reg_idx_t target_mem,
	input  cpu_pkg::word_t    alu_result_mem,
	input  cpu_pkg::word_t    store_data_mem,
	output logic              reg_write_wb,
	output cpu_pkg::reg_idx_t target_wb,
	output cpu_pkg::word_t    wb_data,
	output logic              st_valid,
	output cpu_pkg::word_t    st_addr,
	output cpu_pkg::word_t    st_data
);
	localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);
	localparam cpu_pkg::reg_idx_t ZERO_REG = cpu_pkg::reg_idx_t'(`CPU_ZERO_REG);

	cpu_pkg::word_t     dmem [0:`CPU_DMEM_WORDS-1];
	logic [DMEM_AW-1:0] dmem_idx;

	// Doubleword index, byte offset dropped
	assign dmem_idx = alu_result_mem[DMEM_AW+2:3];

	assign st_valid = valid_mem && mem_write_mem;
	assign st_addr  = alu_result_mem;
	assign st_data  = store_data_mem;

	always_ff @(posedge clk) begin
		if (st_valid)
			dmem[dmem_idx] <= store_data_mem;
	end

	// Writes to X31 are dropped here
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_write_wb <= 1'b0;
			target_wb    <= '0;
		end else begin
			reg_write_wb <= valid_mem && reg_write_mem && (target_mem != ZERO_REG);
			target_wb    <= target_mem;
		end
	end

	// Load data or ALU result
	always_ff @(posedge clk) begin
		wb_data <= mem_read_mem ? dmem[dmem_idx] : alu_result_mem;
	end

endmodule

//--- src/pipeline_top.sv
`timescale 1ns/1ns

// Pipeline top
// ID, EX, MEM and WB stages around the register file and the
// forwarding unit. Writeback and store ports go out directly
module pipeline_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  cpu_pkg::instr_u   instr,
	output logic              wb_valid,
	output cpu_pkg::reg_idx_t wb_reg,
	output cpu_pkg::word_t    wb_data,
	output logic              st_valid,
	output cpu_pkg::word_t    st_addr,
	output cpu_pkg::word_t    st_data
);
	// Register file ports
	cpu_pkg::reg_idx_t rd_addr_a;
	cpu_pkg::reg_idx_t rd_addr_b;
	cpu_pkg::word_t    rd_data_a;
	cpu_pkg::word_t    rd_data_b;

	// ID/EX
	logic              valid_ex;
	logic              reg_write_ex;
	logic              mem_read_ex;
	logic              mem_write_ex;
	cpu_pkg::alu_op_e  alu_op_ex;
	cpu_pkg::fwd_en_e  fwd_en_ex;
	cpu_pkg::reg_idx_t target_ex;
	cpu_pkg::reg_idx_t rn_ex;
	cpu_pkg::reg_idx_t rm_ex;
	cpu_pkg::word_t    op_a_ex;
	cpu_pkg::word_t    op_b_ex;
	cpu_pkg::word_t    imm_ex;

	// Forwarding controls
	cpu_pkg::fwd_sel_e fwd_a;
	cpu_pkg::fwd_sel_e fwd_b;
	logic              store_sel;

	// EX/MEM
	logic              valid_mem;
	logic              reg_write_mem;
	logic              mem_read_mem;
	logic              mem_write_mem;
	cpu_pkg::reg_idx_t target_mem;
	cpu_pkg::word_t    alu_result_mem;
	cpu_pkg::word_t    store_data_mem;

	// MEM/WB
	logic              reg_write_wb;
	cpu_pkg::reg_idx_t target_wb;

	decode_stage u_decode_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.rd_data_a    (rd_data_a),
		.rd_data_b    (rd_data_b),
		.rd_addr_a    (rd_addr_a),
		.rd_addr_b    (rd_addr_b),
		.valid_ex     (valid_ex),
		.reg_write_ex (reg_write_ex),
		.mem_read_ex  (mem_read_ex),
		.mem_write_ex (mem_write_ex),
		.alu_op_ex    (alu_op_ex),
		.fwd_en_ex    (fwd_en_ex),
		.target_ex    (target_ex),
		.rn_ex        (rn_ex),
		.rm_ex        (rm_ex),
		.op_a_ex      (op_a_ex),
		.op_b_ex      (op_b_ex),
		.imm_ex       (imm_ex)
	);

	// Written from the MEM/WB fields
	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.wr_en     (reg_write_wb),
		.wr_addr   (target_wb),
		.wr_data   (wb_data),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	forwarding u_forwarding (
		.fwd_en_ex     (fwd_en_ex),
		.reg_write_ex  (reg_write_ex),
		.reg_write_mem (reg_write_mem),
		.reg_write_wb  (reg_write_wb),
		.target_ex     (target_ex),
		.target_mem    (target_mem),
		.target_wb     (target_wb),
		.rn_ex         (rn_ex),
		.rm_ex         (rm_ex),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.store_sel     (store_sel)
	);

	execute_stage u_execute_stage (
		.clk            (clk),
		.rst_n          (rst_n),
		.valid_ex       (valid_ex),
		.reg_write_ex   (reg_write_ex),
		.mem_read_ex    (mem_read_ex),
		.mem_write_ex   (mem_write_ex),
		.alu_op_ex      (alu_op_ex),
		.fwd_en_ex      (fwd_en_ex),
		.target_ex      (target_ex),
		.op_a_ex        (op_a_ex),
		.op_b_ex        (op_b_ex),
		.imm_ex         (imm_ex),
		.fwd_a          (fwd_a),
		.fwd_b          (fwd_b),
		.store_sel      (store_sel),
		.wb_data        (wb_data),
		.valid_mem      (valid_mem),
		.reg_write_mem  (reg_write_mem),
		.mem_read_mem   (mem_read_mem),
		.mem_write_mem  (mem_write_mem),
		.target_mem     (target_mem),
		.alu_result_mem (alu_result_mem),
		.store_data_mem (store_data_mem)
	);

	memory_stage u_memory_stage (
		.clk            (clk),
		.rst_n          (rst_n),
		.valid_mem      (valid_mem),
		.reg_write_mem  (reg_write_mem),
		.mem_read_mem   (mem_read_mem),
		.mem_write_mem  (mem_write_mem),
		.target_mem     (target_mem),
		.alu_result_mem (alu_result_mem),
		.store_data_mem (store_data_mem),
		.reg_write_wb   (reg_write_wb),
		.target_wb      (target_wb),
		.wb_data        (wb_data),
		.st_valid       (st_valid),
		.st_addr        (st_addr),
		.st_data        (st_data)
	);

	// X31 already filtered out of reg_write_wb
	assign wb_valid = reg_write_wb;
	assign wb_reg   = target_wb;

endmodule

//--- tb/pipeline_properties.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

// Pipeline checker
// Concurrent assertions on the forwarding select, store port timing
// and the output ports during reset
module pipeline_properties (
	input logic              clk,
	input logic              rst_n,
	input logic              instr_valid,
	input cpu_pkg::instr_u   instr,
	input cpu_pkg::fwd_sel_e fwd_a,
	input cpu_pkg::reg_idx_t target_mem,
	input logic              wb_valid,
	input logic              st_valid
);
	localparam cpu_pkg::reg_idx_t ZERO_REG = cpu_pkg::reg_idx_t'(`CPU_ZERO_REG);

	logic store_strobe;

	// Strobe carrying a STUR
	assign store_strobe = instr_valid && (instr.d_fmt.opcode == cpu_pkg::OP_STUR);

	// X31 result in EX/MEM is never a source for operand A
	zero_reg_not_forwarded: assert property (@(posedge clk) disable iff (!rst_n)
		(target_mem == ZERO_REG) |-> (fwd_a != cpu_pkg::FWD_EX_MEM))
		else $error("fwd_a selects EX/MEM while target_mem is X31");

	// Store port two cycles after the strobe, never otherwise
	store_two_cycles: assert property (@(posedge clk) disable iff (!rst_n)
		st_valid == $past(store_strobe, 2))
		else $error("st_valid not two cycles after a store strobe");

	ports_quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> (!wb_valid && !st_valid))
		else $error("wb_valid or st_valid high during reset");

endmodule

// fwd_a and target_mem are the forwarding unit's ports as wired in the top
bind pipeline_top pipeline_properties u_pipeline_properties (
	.clk         (clk),
	.rst_n       (rst_n),
	.instr_valid (instr_valid),
	.instr       (instr),
	.fwd_a       (fwd_a),
	.target_mem  (target_mem),
	.wb_valid    (wb_valid),
	.st_valid    (st_valid)
);

//--- tb/pipeline_tb.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

// Pipeline testbench
// Directed forwarding cases and a random program, checked against a
// sequential model of registers and data memory
module pipeline_tb;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 2;
	localparam int RANDOM_COUNT = 300;
	localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);
	localparam cpu_pkg::reg_idx_t ZERO_REG = cpu_pkg::reg_idx_t'(`CPU_ZERO_REG);
	// Memory fill, directed cases, random mix at up to four cycles each
	localparam int RUN_CYCLES = RESET_CYCLES + 2 * `CPU_DMEM_WORDS + 80 + 4 * RANDOM_COUNT;
	localparam int WATCHDOG_NS = CLK_PERIOD * (RUN_CYCLES + 100);

	logic              clk;
	logic              rst_n;
	logic              instr_valid;
	cpu_pkg::instr_u   instr;
	logic              wb_valid;
	cpu_pkg::reg_idx_t wb_reg;
	cpu_pkg::word_t    wb_data;
	logic              st_valid;
	cpu_pkg::word_t    st_addr;
	cpu_pkg::word_t    st_data;

	// Sequential model state
	cpu_pkg::word_t    model_regs [0:31];
	cpu_pkg::word_t    model_mem [0:`CPU_DMEM_WORDS-1];
	// Expected results, program order
	cpu_pkg::reg_idx_t exp_wb_reg [$];
	cpu_pkg::word_t    exp_wb_data [$];
	cpu_pkg::word_t    exp_st_addr [$];
	cpu_pkg::word_t    exp_st_data [$];
	int                wb_checked;
	int                st_checked;
	cpu_pkg::instr_u   rnd_ins;
	int unsigned       gap;

	pipeline_top u_pipeline_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.st_valid    (st_valid),
		.st_addr     (st_addr),
		.st_data     (st_data)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	function automatic cpu_pkg::instr_u encode_r(input logic [10:0] opc,
			input cpu_pkg::reg_idx_t rd, input cpu_pkg::reg_idx_t rn,
			input cpu_pkg::reg_idx_t rm);
		cpu_pkg::instr_u w;
		w.r_fmt.opcode = opc;
		w.r_fmt.rm = rm;
		w.r_fmt.shamt = '0;
		w.r_fmt.rn = rn;
		w.r_fmt.rd = rd;
		return w;
	endfunction

	function automatic cpu_pkg::instr_u encode_i(input logic [9:0] opc,
			input cpu_pkg::reg_idx_t rd, input cpu_pkg::reg_idx_t rn, input logic [11:0] imm);
		cpu_pkg::instr_u w;
		w.i_fmt.opcode = opc;
		w.i_fmt.imm = imm;
		w.i_fmt.rn = rn;
		w.i_fmt.rd = rd;
		return w;
	endfunction

	function automatic cpu_pkg::instr_u encode_d(input logic [10:0] opc,
			input cpu_pkg::reg_idx_t rt, input cpu_pkg::reg_idx_t rn, input logic [8:0] off);
		cpu_pkg::instr_u w;
		w.d_fmt.opcode = opc;
		w.d_fmt.addr = off;
		w.d_fmt.op2 = '0;
		w.d_fmt.rn = rn;
		w.d_fmt.rt = rt;
		return w;
	endfunction

	function automatic cpu_pkg::word_t model_read(input cpu_pkg::reg_idx_t idx);
		return (idx == ZERO_REG) ? '0 : model_regs[idx];
	endfunction

	// Reference: runs one instruction to completion and queues its results
	function automatic void model_execute(input cpu_pkg::instr_u ins);
		cpu_pkg::word_t    a;
		cpu_pkg::word_t    b;
		cpu_pkg::word_t    imm;
		cpu_pkg::word_t    addr;
		cpu_pkg::word_t    res;
		cpu_pkg::reg_idx_t dest;
		logic              writes;
		a = model_read(ins.r_fmt.rn);
		b = model_read(ins.r_fmt.rm);
		imm = cpu_pkg::word_t'(ins.i_fmt.imm);
		// D offset is signed 9 bits
		addr = a + cpu_pkg::word_t'($signed(ins.d_fmt.addr));
		dest = ins.r_fmt.rd;
		writes = 1'b1;
		case (ins.r_fmt.opcode)
			cpu_pkg::OP_ADD: res = a + b;
			cpu_pkg::OP_SUB: res = a - b;
			cpu_pkg::OP_AND: res = a & b;
			cpu_pkg::OP_ORR: res = a | b;
			cpu_pkg::OP_LDUR: res = model_mem[addr[DMEM_AW+2:3]];
			cpu_pkg::OP_STUR: begin
				writes = 1'b0;
				res = model_read(ins.d_fmt.rt);
				model_mem[addr[DMEM_AW+2:3]] = res;
				exp_st_addr.push_back(addr);
				exp_st_data.push_back(res);
			end
			// Only ADDI and SUBI are generated here
			default: res = (ins.i_fmt.opcode == cpu_pkg::OP_SUBI) ? a - imm : a + imm;
		endcase
		// X31 target leaves no writeback
		if (writes && dest != ZERO_REG) begin
			model_regs[dest] = res;
			exp_wb_reg.push_back(dest);
			exp_wb_data.push_back(res);
		end
	endfunction

	// Mostly X0..X7 for dense dependences, sometimes X31
	function automatic cpu_pkg::reg_idx_t pick_reg();
		int unsigned r;
		r = $urandom_range(0, 8);
		return (r == 8) ? ZERO_REG : cpu_pkg::reg_idx_t'(r);
	endfunction

	function automatic cpu_pkg::instr_u random_instr();
		int unsigned       kind;
		cpu_pkg::reg_idx_t rd;
		cpu_pkg::reg_idx_t rn;
		cpu_pkg::reg_idx_t rm;
		cpu_pkg::instr_u   w;
		kind = $urandom_range(0, 7);
		rd = pick_reg();
		rn = pick_reg();
		rm = pick_reg();
		case (kind)
			0: w = encode_r(cpu_pkg::OP_ADD, rd, rn, rm);
			1: w = encode_r(cpu_pkg::OP_SUB, rd, rn, rm);
			2: w = encode_r(cpu_pkg::OP_AND, rd, rn, rm);
			3: w = encode_r(cpu_pkg::OP_ORR, rd, rn, rm);
			4: w = encode_i(cpu_pkg::OP_ADDI, rd, rn, 12'($urandom_range(0, 4095)));
			5: w = encode_i(cpu_pkg::OP_SUBI, rd, rn, 12'($urandom_range(0, 4095)));
			6: w = encode_d(cpu_pkg::OP_LDUR, rd, rn, 9'($urandom_range(0, 511)));
			default: w = encode_d(cpu_pkg::OP_STUR, rd, rn, 9'($urandom_range(0, 511)));
		endcase
		return w;
	endfunction

	// One strobe, held a single cycle unless another issue follows
	task automatic issue(input cpu_pkg::instr_u ins);
		@(posedge clk);
		#DRIVE_DELAY;
		instr = ins;
		instr_valid = 1'b1;
		model_execute(ins);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#DRIVE_DELAY;
			instr_valid = 1'b0;
		end
	endtask

	task automatic check_wb(input cpu_pkg::reg_idx_t got_reg, input cpu_pkg::word_t got_data,
			input cpu_pkg::reg_idx_t exp_reg, input cpu_pkg::word_t exp_data);
		if (got_reg !== exp_reg) begin
			$display("[FAIL] %0t wb_reg got %0d expected %0d", $time, got_reg, exp_reg);
			abort_run();
		end
		if (got_data !== exp_data) begin
			$display("[FAIL] %0t wb_data got %h expected %h", $time, got_data, exp_data);
			abort_run();
		end
	endtask

	task automatic check_store(input cpu_pkg::word_t got_addr, input cpu_pkg::word_t got_data,
			input cpu_pkg::word_t exp_addr, input cpu_pkg::word_t exp_data);
		if (got_addr !== exp_addr) begin
			$display("[FAIL] %0t st_addr got %h expected %h", $time, got_addr, exp_addr);
			abort_run();
		end
		if (got_data !== exp_data) begin
			$display("[FAIL] %0t st_data got %h expected %h", $time, got_data, exp_data);
			abort_run();
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			if (exp_wb_reg.size() == 0) begin
				$display("Writeback to X%0d at %0t with no result pending in the model",
					wb_reg, $time);
				abort_run();
			end else begin
				check_wb(wb_reg, wb_data, exp_wb_reg.pop_front(), exp_wb_data.pop_front());
				wb_checked++;
			end
		end
		if (rst_n && st_valid) begin
			if (exp_st_addr.size() == 0) begin
				$display("Store at %0t with no store pending in the model", $time);
				abort_run();
			end else begin
				check_store(st_addr, st_data, exp_st_addr.pop_front(), exp_st_data.pop_front());
				st_checked++;
			end
		end
	end

	initial begin
		#WATCHDOG_NS;
		$display("Watchdog expired at %0t before the tests finished", $time);
		abort_run();
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		wb_checked = 0;
		st_checked = 0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		void'($urandom(94));
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		// Fill every doubleword, value depends on the index
		for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
			issue(encode_i(cpu_pkg::OP_ADDI, 5'd1, ZERO_REG, 12'(i * 131 + 7)));
			issue(encode_d(cpu_pkg::OP_STUR, 5'd1, ZERO_REG, 9'(i * 8)));
		end
		idle(4);

		// Back-to-back through EX/MEM
		issue(encode_i(cpu_pkg::OP_ADDI, 5'd1, ZERO_REG, 12'd100));
		issue(encode_r(cpu_pkg::OP_ADD, 5'd2, 5'd1, 5'd1));
		issue(encode_i(cpu_pkg::OP_SUBI, 5'd3, 5'd2, 12'd7));
		issue(encode_r(cpu_pkg::OP_AND, 5'd4, 5'd3, 5'd2));
		issue(encode_r(cpu_pkg::OP_ORR, 5'd5, 5'd4, 5'd1));
		idle(4);

		// Distance two alone, then both sources on X9
		issue(encode_i(cpu_pkg::OP_ADDI, 5'd6, ZERO_REG, 12'd50));
		issue(encode_i(cpu_pkg::OP_ADDI, 5'd7, ZERO_REG, 12'd9));
		issue(encode_r(cpu_pkg::OP_SUB, 5'd8, 5'd6, ZERO_REG));
		issue(encode_i(cpu_pkg::OP_ADDI, 5'd9, ZERO_REG, 12'd1));
		issue(encode_i(cpu_pkg::OP_ADDI, 5'd9, ZERO_REG, 12'd2));
		issue(encode_r(cpu_pkg::OP_ADD, 5'd10, 5'd9, 5'd9));
		idle(4);

		// X31 as target, readers must still see zero
		issue(encode_i(cpu_pkg::OP_ADDI, ZERO_REG, ZERO_REG, 12'd77));
		issue(encode_r(cpu_pkg::OP_ADD, 5'd12, ZERO_REG, ZERO_REG));
		issue(encode_i(cpu_pkg::OP_ADDI, ZERO_REG, 5'd1, 12'd5));
		issue(encode_i(cpu_pkg::OP_ADDI, 5'd2, 5'd2, 12'd3));
		issue(encode_r(cpu_pkg::OP_ORR, 5'd13, ZERO_REG, 5'd1));
		idle(4);

		// STUR with Rt one back and Rn two back, then swapped
		issue(encode_i(cpu_pkg::OP_ADDI, 5'd14, ZERO_REG, 12'd64));
		issue(encode_i(cpu_pkg::OP_ADDI, 5'd15, ZERO_REG, 12'd999));
		issue(encode_d(cpu_pkg::OP_STUR, 5'd15, 5'd14, 9'd8));
		issue(encode_i(cpu_pkg::OP_ADDI, 5'd16, ZERO_REG, 12'd3));
		issue(encode_i(cpu_pkg::OP_ADDI, 5'd17, ZERO_REG, 12'd16));
		issue(encode_d(cpu_pkg::OP_STUR, 5'd16, 5'd17, 9'd0));
		idle(4);

		// Loads, one idle cycle, then consumers on the MEM/WB path
		issue(encode_d(cpu_pkg::OP_LDUR, 5'd18, 5'd14, 9'd8));
		idle(1);
		issue(encode_r(cpu_pkg::OP_ADD, 5'd19, 5'd18, 5'd1));
		issue(encode_d(cpu_pkg::OP_LDUR, 5'd20, 5'd17, 9'd0));
		idle(1);
		issue(encode_d(cpu_pkg::OP_STUR, 5'd20, 5'd14, 9'h1f8));
		idle(4);

		// Random mix, a load always gets at least one idle cycle
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			rnd_ins = random_instr();
			issue(rnd_ins);
			gap = ($urandom_range(0, 1) == 0) ? 0 : $urandom_range(1, 3);
			if (rnd_ins.d_fmt.opcode == cpu_pkg::OP_LDUR && gap == 0)
				gap = 1;
			if (gap > 0)
				idle(int'(gap));
		end
		idle(6);

		$display("Checked %0d writebacks and %0d stores", wb_checked, st_checked);
		if (exp_wb_reg.size() != 0 || exp_st_addr.size() != 0) begin
			$display("Results never appeared: %0d writebacks, %0d stores",
				exp_wb_reg.size(), exp_st_addr.size());
			abort_run();
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

//--- src.f
+incdir+src
src/cpu_pkg.sv
src/forwarding.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/pipeline_top.sv
tb/pipeline_properties.sv
tb/pipeline_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the pipeline testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module pipeline_tb -f src.f -o pipeline_sim \
	&& ./obj_dir/pipeline_sim 2>&1 | tee sim.log \
	|| echo "Build or simulation did not complete"
grep -qsx "TEST PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
